// File: src.f
+incdir+hdl
hdl/tlp_rx_pkg.sv
hdl/tlp_axis_skid.sv
hdl/tlp_rx_decode.sv
hdl/tlp_seg_fifo.sv
hdl/tlp_len_check.sv
hdl/tlp_rx_top.sv
test/tb_clkgen.sv
test/tb_tlp_rx.sv

// File: Makefile
# Verilator flow for the tlp rx path

VERILATOR ?= verilator
TOP       ?= tb_tlp_rx
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST PASSED
VFLAGS    ?= --timing --assert
SIMFLAGS  ?= -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) $(SIMFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/tb_tlp_rx.sv
// ~~~~~~~~~~~~~~~~~~~~
// tlp rx testbench: random tlps, segment model,
// compare tasks, back-pressure, watchdog
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/10ps

`include "tlp_rx_params.svh"

module tb_tlp_rx;
  import tlp_rx_pkg::*;

  localparam int N_TLP       = 300;
  localparam int CYC_PER_TLP = 40;
  localparam int CLK_NS      = 100;
  localparam int DRIVE_DLY   = 1;
  // longest wait for in_ready on one beat
  localparam int STALL_MAX   = 500;

  logic      clk_i;
  logic      rst_i;
  tlp_word_t in_word;
  logic      in_valid;
  logic      in_ready;
  tlp_seg_t  rx_seg;
  logic      rx_valid;
  logic      rx_ready;

  // expected segments, in arrival order
  tlp_seg_t    exp_q[$];
  // beats of the tlp about to be sent
  tlp_word_t   words[$];
  // raw header words in wire order
  logic [31:0] hw[4];
  int          n_expected;
  int          n_checked;
  int          stall_left;
  logic        rst_prev;

  tb_clkgen #(.PERIOD_NS(CLK_NS), .RST_CYCLES(4)) clkgen_i (
    .clk_i (clk_i),
    .rst_i (rst_i)
  );

  tlp_rx_top tlp_rx_top_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .in_word  (in_word),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .rx_seg   (rx_seg),
    .rx_valid (rx_valid),
    .rx_ready (rx_ready)
  );

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  // byte 0 of the wire word ends up lowest
  function automatic logic [31:0] swap_bytes(input logic [31:0] w);
    logic [31:0] r;
    for (int b = 0; b < 4; b++) begin
      r[8*b +: 8] = w[8*(3-b) +: 8];
    end
    return r;
  endfunction

  function automatic logic [31:0] make_dw0(input logic [2:0] fmt, input logic [9:0] len);
    logic [4:0]  typ;
    logic [13:0] attr;
    typ  = 5'($urandom);
    attr = 14'($urandom);
    return {fmt, typ, attr, len};
  endfunction

  // swapped header words 0..nwords-1, the rest zero
  function automatic logic [127:0] hdr_image(input int nwords);
    logic [127:0] h;
    h = '0;
    for (int i = 0; i < nwords; i++) begin
      h[127-32*i -: 32] = swap_bytes(hw[i]);
    end
    return h;
  endfunction

  task automatic fill_header(input logic [2:0] fmt, input logic [9:0] len);
    hw[0] = make_dw0(fmt, len);
    for (int i = 1; i < 4; i++) begin
      hw[i] = $urandom;
    end
  endtask

  task automatic add_word(input logic [31:0] data, input logic last);
    tlp_word_t w;
    w.data = data;
    w.last = last;
    words.push_back(w);
  endtask

  task automatic push_seg(input logic [127:0] hdr, input logic [`TLP_SEG_W-1:0] data,
                          input logic [`TLP_SEG_DW-1:0] strb, input logic sop,
                          input logic eop, input logic [3:0] err);
    tlp_seg_t s;
    s.hdr  = hdr;
    s.data = data;
    s.strb = strb;
    s.sop  = sop;
    s.eop  = eop;
    s.err  = err;
    exp_q.push_back(s);
    n_expected++;
  endtask

  // one random tlp into words, its segments into exp_q
  task automatic build_tlp();
    int                     kind;
    int                     hsz;
    int                     n;
    int                     k;
    int                     nseg;
    int                     exp_len;
    logic [2:0]             fmt;
    logic [9:0]             len;
    logic                   mism;
    logic [31:0]            pl[$];
    logic [`TLP_SEG_W-1:0]  data;
    logic [`TLP_SEG_DW-1:0] strb;
    words.delete();
    kind = $urandom % 100;
    if (kind < 15) begin
      // header only, last on the final header word
      fmt = ($urandom % 2) ? 3'd1 : 3'd0;
      hsz = fmt[0] ? 4 : 3;
      fill_header(fmt, 10'($urandom));
      for (int i = 0; i < hsz; i++) begin
        add_word(hw[i], i == hsz - 1);
      end
      push_seg(hdr_image(hsz), '0, '0, 1'b1, 1'b1, 4'b0000);
    end else if (kind < 90) begin
      // with data, length wrong for kind 80..89
      fmt = ($urandom % 2) ? 3'd3 : 3'd2;
      hsz = fmt[0] ? 4 : 3;
      n   = 1 + $urandom % 16;
      len = 10'(n);
      if (kind >= 80) begin
        while (len == 10'(n)) begin
          len = 10'($urandom);
        end
      end
      exp_len = (len == 10'd0) ? 1024 : int'(len);
      mism    = (exp_len != n);
      fill_header(fmt, len);
      for (int i = 0; i < hsz; i++) begin
        add_word(hw[i], 1'b0);
      end
      for (int i = 0; i < n; i++) begin
        pl.push_back($urandom);
        add_word(pl[i], i == n - 1);
      end
      nseg = (n + `TLP_SEG_DW - 1) / `TLP_SEG_DW;
      for (int s = 0; s < nseg; s++) begin
        data = '0;
        strb = '0;
        for (int j = 0; j < `TLP_SEG_DW; j++) begin
          k = s * `TLP_SEG_DW + j;
          if (k < n) begin
            data[`TLP_SEG_W-1-32*j -: 32] = swap_bytes(pl[k]);
            strb[`TLP_SEG_DW-1-j]         = 1'b1;
          end
        end
        push_seg(hdr_image(hsz), data, strb, s == 0, s == nseg - 1,
                 (s == nseg - 1 && mism) ? 4'b0010 : 4'b0000);
      end
    end else if (kind < 94) begin
      // early last, a data tlp may also end on its last header word
      fmt = 3'($urandom % 4);
      hsz = fmt[0] ? 4 : 3;
      k   = 1 + $urandom % (fmt[1] ? hsz : hsz - 1);
      fill_header(fmt, 10'($urandom));
      for (int i = 0; i < k; i++) begin
        add_word(hw[i], i == k - 1);
      end
      push_seg(hdr_image(k), '0, '0, 1'b1, 1'b1, 4'b0001);
    end else if (kind < 97) begin
      // no-data tlp without last, tail dropped
      fmt = ($urandom % 2) ? 3'd1 : 3'd0;
      hsz = fmt[0] ? 4 : 3;
      n   = 1 + $urandom % 3;
      fill_header(fmt, 10'($urandom));
      for (int i = 0; i < hsz; i++) begin
        add_word(hw[i], 1'b0);
      end
      for (int i = 0; i < n; i++) begin
        add_word($urandom, i == n - 1);
      end
      push_seg(hdr_image(hsz), '0, '0, 1'b1, 1'b1, 4'b0001);
    end else begin
      // fmt 4..7, only dw0 kept
      fmt = 3'(4 + $urandom % 4);
      n   = 1 + $urandom % 6;
      fill_header(fmt, 10'($urandom));
      add_word(hw[0], n == 1);
      for (int i = 1; i < n; i++) begin
        add_word($urandom, i == n - 1);
      end
      push_seg(hdr_image(1), '0, '0, 1'b1, 1'b1, 4'b0001);
    end
  endtask

  // hold the beat until in_ready, sampled mid-cycle
  task automatic send_word(input tlp_word_t w);
    int   waited;
    logic took;
    in_word  = w;
    in_valid = 1'b1;
    waited   = 0;
    took     = 1'b0;
    while (!took) begin
      @(negedge clk_i);
      took = in_ready;
      @(posedge clk_i);
      #DRIVE_DLY;
      waited++;
      if (!took && waited > STALL_MAX) begin
        $display("in_ready stayed low for %0d cycles while in_valid was high", waited);
        abort_run();
      end
    end
    if ($urandom % 5 == 0) begin
      // idle gap with junk on the data lines
      in_valid     = 1'b0;
      in_word.data = $urandom;
      repeat (1 + $urandom % 3) begin
        @(posedge clk_i);
        #DRIVE_DLY;
      end
    end
  endtask

  task automatic cmp_valid(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("ERR t=%0t %s got %b exp %b", $time, name, got, want);
      abort_run();
    end
  endtask

  task automatic cmp_seg_hdr(input tlp_seg_t got, input tlp_seg_t want);
    if (got.hdr !== want.hdr) begin
      $display("ERR t=%0t rx_seg.hdr got %h exp %h", $time, got.hdr, want.hdr);
      abort_run();
    end
  endtask

  task automatic cmp_seg_data(input tlp_seg_t got, input tlp_seg_t want);
    if (got.data !== want.data) begin
      $display("ERR t=%0t rx_seg.data got %h exp %h", $time, got.data, want.data);
      abort_run();
    end
    if (got.strb !== want.strb) begin
      $display("ERR t=%0t rx_seg.strb got %b exp %b", $time, got.strb, want.strb);
      abort_run();
    end
  endtask

  task automatic cmp_seg_flags(input tlp_seg_t got, input tlp_seg_t want);
    if (got.sop !== want.sop) begin
      $display("ERR t=%0t rx_seg.sop got %b exp %b", $time, got.sop, want.sop);
      abort_run();
    end
    if (got.eop !== want.eop) begin
      $display("ERR t=%0t rx_seg.eop got %b exp %b", $time, got.eop, want.eop);
      abort_run();
    end
    if (got.err !== want.err) begin
      $display("ERR t=%0t rx_seg.err got %b exp %b", $time, got.err, want.err);
      abort_run();
    end
  endtask

  // random rx_ready with occasional long stalls
  always @(posedge clk_i) begin
    #DRIVE_DLY;
    if (stall_left > 0) begin
      rx_ready = 1'b0;
      stall_left--;
    end else if ($urandom % 32 == 0) begin
      rx_ready   = 1'b0;
      stall_left = 4 + $urandom % 16;
    end else begin
      rx_ready = ($urandom % 4 != 0);
    end
  end

  // output monitor, a transfer happens on the next rising edge
  always @(negedge clk_i) begin
    tlp_seg_t want;
    // held low through reset and on the cycle after it
    if (rst_prev === 1'b1) begin
      cmp_valid("rx_valid", rx_valid, 1'b0);
      cmp_valid("in_ready", in_ready, 1'b0);
    end
    rst_prev = rst_i;
    if (!rst_i && rx_valid && rx_ready) begin
      if (exp_q.size() == 0) begin
        $display("segment delivered at t=%0t while none was expected", $time);
        abort_run();
      end else begin
        want = exp_q.pop_front();
        cmp_seg_hdr(rx_seg, want);
        cmp_seg_data(rx_seg, want);
        cmp_seg_flags(rx_seg, want);
        n_checked++;
      end
    end
  end

  initial begin
    #(N_TLP * CYC_PER_TLP * CLK_NS);
    $display("timeout: run did not finish within %0d cycles, %0d segments still expected",
             N_TLP * CYC_PER_TLP, exp_q.size());
    abort_run();
  end

  initial begin
    void'($urandom(32'h3d2d));
    in_word    = '0;
    in_valid   = 1'b0;
    rx_ready   = 1'b0;
    stall_left = 0;
    n_expected = 0;
    n_checked  = 0;
    rst_prev   = 1'b0;
    while (rst_i !== 1'b0) begin
      @(posedge clk_i);
    end
    #DRIVE_DLY;
    for (int t = 0; t < N_TLP; t++) begin
      build_tlp();
      foreach (words[i]) begin
        send_word(words[i]);
      end
    end
    in_valid = 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    // quiet time to catch stray segments
    repeat (50) @(posedge clk_i);
    @(negedge clk_i);
    // drained path, nothing offered and input open again
    if (exp_q.size() == 0 && n_checked == n_expected &&
        rx_valid === 1'b0 && in_ready === 1'b1) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("DUT not idle after the last segment: %0d of %0d checked, rx_valid %b in_ready %b",
               n_checked, n_expected, rx_valid, in_ready);
      abort_run();
    end
  end

endmodule

`default_nettype wire

// File: test/tb_clkgen.sv
// ~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset source
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/10ps

module tb_clkgen #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 4
) (
  output logic clk_i,
  output logic rst_i
);

  initial begin
    clk_i = 1'b0;
    forever #(PERIOD_NS / 2) clk_i = ~clk_i;
  end

  // sync reset, released just after an edge
  initial begin
    rst_i = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
  end

endmodule

`default_nettype wire

// File: hdl/tlp_rx_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// tlp rx path top: decoder, fifo, length check
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/10ps

module tlp_rx_top (
  input  wire                    clk_i,
  input  wire                    rst_i,
  input  tlp_rx_pkg::tlp_word_t  in_word,
  input  wire                    in_valid,
  output logic                   in_ready,
  output tlp_rx_pkg::tlp_seg_t   rx_seg,
  output logic                   rx_valid,
  input  wire                    rx_ready
);
  import tlp_rx_pkg::*;

  // decoder to fifo
  tlp_seg_t dec_seg;
  logic     dec_valid;
  logic     dec_ready;

  // fifo to length check
  tlp_seg_t fifo_seg;
  logic     fifo_valid;
  logic     fifo_ready;

  tlp_rx_decode decode_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .in_word   (in_word),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .seg       (dec_seg),
    .seg_valid (dec_valid),
    .seg_ready (dec_ready)
  );

  tlp_seg_fifo fifo_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .in_seg    (dec_seg),
    .in_valid  (dec_valid),
    .in_ready  (dec_ready),
    .out_seg   (fifo_seg),
    .out_valid (fifo_valid),
    .out_ready (fifo_ready)
  );

  tlp_len_check len_check_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .in_seg   (fifo_seg),
    .in_valid (fifo_valid),
    .in_ready (fifo_ready),
    .rx_seg   (rx_seg),
    .rx_valid (rx_valid),
    .rx_ready (rx_ready)
  );

endmodule

`default_nettype wire

// File: hdl/tlp_len_check.sv
// ~~~~~~~~~~~~~~~~~~~~
// payload dw count vs header length,
// output segment register
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/10ps

`include "tlp_rx_params.svh"

module tlp_len_check (
  input  wire                   clk_i,
  input  wire                   rst_i,
  input  tlp_rx_pkg::tlp_seg_t  in_seg,
  input  wire                   in_valid,
  output logic                  in_ready,
  output tlp_rx_pkg::tlp_seg_t  rx_seg,
  output logic                  rx_valid,
  input  wire                   rx_ready
);
  import tlp_rx_pkg::*;

  localparam int PC_W = $clog2(`TLP_SEG_DW) + 1;

  tlp_dw0_u    dw0;
  logic [PC_W-1:0] seg_cnt;
  // up to 1024 dw plus headroom
  logic [10:0] dw_cnt;
  logic [10:0] total;
  logic [10:0] exp_len;
  logic        mismatch;
  logic        load;
  // inside a tlp, sop seen without eop
  logic        in_tlp;

  assign in_ready = !rx_valid || rx_ready;
  assign load     = in_valid && in_ready;

  // hdr word 0 back to wire order before decoding
  assign dw0.raw = dw_swap(in_seg.hdr[127:96]);
  // length 0 reads as 1024
  assign exp_len = {(dw0.f.length == 10'd0), dw0.f.length};

  always_comb begin
    seg_cnt = '0;
    for (int i = 0; i < `TLP_SEG_DW; i++) begin
      seg_cnt = seg_cnt + PC_W'(in_seg.strb[i]);
    end
  end

  assign total    = (in_seg.sop ? 11'd0 : dw_cnt) + 11'(seg_cnt);
  // no-data formats and malformed tlps skip the check
  assign mismatch = in_seg.eop && !in_seg.err[0] && (total != exp_len) &&
                    (dw0.f.fmt inside {fmt_3dw_wd, fmt_4dw_wd});

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rx_valid <= 1'b0;
      dw_cnt   <= '0;
      in_tlp   <= 1'b0;
    end else begin
      if (in_ready) begin
        rx_valid <= in_valid;
      end
      if (load) begin
        dw_cnt <= total;
        in_tlp <= !in_seg.eop;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      rx_seg     <= in_seg;
      rx_seg.err <= in_seg.err | {2'b00, mismatch, 1'b0};
    end
  end

  // after eop the next segment opens a new tlp
  assert property (@(posedge clk_i) disable iff (rst_i)
    (load && !in_tlp) |-> in_seg.sop);

endmodule

`default_nettype wire

// File: hdl/tlp_seg_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~
// first-word-fall-through segment fifo
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/10ps

`include "tlp_rx_params.svh"

module tlp_seg_fifo (
  input  wire                   clk_i,
  input  wire                   rst_i,
  input  tlp_rx_pkg::tlp_seg_t  in_seg,
  input  wire                   in_valid,
  output logic                  in_ready,
  output tlp_rx_pkg::tlp_seg_t  out_seg,
  output logic                  out_valid,
  input  wire                   out_ready
);
  import tlp_rx_pkg::*;

  localparam int AW = $clog2(`TLP_FIFO_DEPTH);

  tlp_seg_t mem [`TLP_FIFO_DEPTH];

  // extra msb tells full from empty
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic [AW:0] wr_ptr_n;
  logic [AW:0] rd_ptr_n;
  logic        full;
  logic        wr_en;
  logic        rd_en;
  // entries held, from the pointer distance
  logic [AW:0] count;

  assign full     = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign in_ready = !full;
  assign wr_en    = in_valid && in_ready;
  assign rd_en    = out_valid && out_ready;
  assign wr_ptr_n = wr_ptr + (AW+1)'(wr_en);
  assign rd_ptr_n = rd_ptr + (AW+1)'(rd_en);
  assign count    = wr_ptr - rd_ptr;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      out_valid <= 1'b0;
    end else begin
      wr_ptr    <= wr_ptr_n;
      rd_ptr    <= rd_ptr_n;
      // valid a cycle after the write lands
      out_valid <= (wr_ptr_n != rd_ptr_n);
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem[wr_ptr[AW-1:0]] <= in_seg;
    end
  end

  // head entry shown straight from the array
  assign out_seg = mem[rd_ptr[AW-1:0]];

  assert property (@(posedge clk_i) disable iff (rst_i) wr_en |-> (count < `TLP_FIFO_DEPTH));
  assert property (@(posedge clk_i) disable iff (rst_i) rd_en |-> (wr_ptr != rd_ptr));

endmodule

`default_nettype wire

// File: hdl/tlp_rx_decode.sv
// ~~~~~~~~~~~~~~~~~~~~
// tlp rx decoder: header assembly, byte swap,
// payload packing into segments, malformed flagging
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/10ps

`include "tlp_rx_params.svh"

module tlp_rx_decode (
  input  wire                    clk_i,
  input  wire                    rst_i,
  input  tlp_rx_pkg::tlp_word_t  in_word,
  input  wire                    in_valid,
  output logic                   in_ready,
  output tlp_rx_pkg::tlp_seg_t   seg,
  output logic                   seg_valid,
  input  wire                    seg_ready
);
  import tlp_rx_pkg::*;

  localparam int CNT_W = $clog2(`TLP_SEG_DW);

  typedef enum logic [2:0] {
    st_idle,
    st_hdr1,
    st_hdr2,
    st_hdr3,
    st_stream,
    st_send,
    st_drain
  } dec_state_e;

  dec_state_e state;

  // skid side of the word stream
  tlp_word_t s_word;
  logic      s_valid;
  logic      s_ready;

  // dw0 of the incoming word, raw and decoded
  tlp_dw0_u  dw0;
  logic      fmt_ok;
  logic [31:0] word_sw;

  // header and payload under construction
  logic [0:3][31:0]             hdr_q;
  logic [0:`TLP_SEG_DW-1][31:0] data_q;
  logic [0:`TLP_SEG_DW-1]       strb_q;
  logic [CNT_W-1:0]             cnt;
  logic                         sop_q;
  logic                         eop_q;
  logic                         mal_q;
  logic                         is_4dw;
  logic                         has_data;

  // header slot and completion for the hdr states
  logic [1:0] hdr_idx;
  logic       hdr_done;

  tlp_axis_skid skid_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .in_word   (in_word),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_word  (s_word),
    .out_valid (s_valid),
    .out_ready (s_ready)
  );

  assign dw0.raw = s_word.data;
  assign word_sw = dw_swap(s_word.data);
  assign fmt_ok  = dw0.f.fmt inside {fmt_3dw_nd, fmt_4dw_nd, fmt_3dw_wd, fmt_4dw_wd};

  always_comb begin
    hdr_idx  = 2'd1;
    hdr_done = 1'b0;
    case (state)
      st_hdr2: begin
        hdr_idx  = 2'd2;
        hdr_done = !is_4dw;
      end
      st_hdr3: begin
        hdr_idx  = 2'd3;
        hdr_done = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // every state but send takes a word per cycle
  assign s_ready   = (state != st_send);
  assign seg_valid = (state == st_send);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state <= st_idle;
      sop_q <= 1'b0;
      eop_q <= 1'b0;
      mal_q <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (s_valid) begin
            // fresh tlp, word 1..3 start at zero
            hdr_q    <= {word_sw, 96'd0};
            data_q   <= '0;
            strb_q   <= '0;
            cnt      <= '0;
            sop_q    <= 1'b1;
            eop_q    <= 1'b0;
            mal_q    <= 1'b0;
            is_4dw   <= dw0.f.fmt inside {fmt_4dw_nd, fmt_4dw_wd};
            has_data <= dw0.f.fmt inside {fmt_3dw_wd, fmt_4dw_wd};
            if (s_word.last) begin
              // single word tlp, header cut short
              mal_q <= 1'b1;
              eop_q <= 1'b1;
              state <= st_send;
            end else if (!fmt_ok) begin
              mal_q <= 1'b1;
              state <= st_drain;
            end else begin
              state <= st_hdr1;
            end
          end
        end
        st_hdr1, st_hdr2, st_hdr3: begin
          if (s_valid) begin
            hdr_q[hdr_idx] <= word_sw;
            if (s_word.last && (!hdr_done || has_data)) begin
              // early last, or data tlp ending on its header
              mal_q <= 1'b1;
              eop_q <= 1'b1;
              state <= st_send;
            end else if (!hdr_done) begin
              state <= (state == st_hdr1) ? st_hdr2 : st_hdr3;
            end else if (has_data) begin
              state <= st_stream;
            end else if (s_word.last) begin
              eop_q <= 1'b1;
              state <= st_send;
            end else begin
              // no-data tlp without last, drop the tail
              mal_q <= 1'b1;
              state <= st_drain;
            end
          end
        end
        st_stream: begin
          if (s_valid) begin
            data_q[cnt] <= word_sw;
            strb_q[cnt] <= 1'b1;
            cnt         <= cnt + 1'b1;
            if (s_word.last) begin
              eop_q <= 1'b1;
              state <= st_send;
            end else if (cnt == CNT_W'(`TLP_SEG_DW - 1)) begin
              state <= st_send;
            end
          end
        end
        st_send: begin
          if (seg_ready) begin
            // next segment of the same tlp keeps hdr
            data_q <= '0;
            strb_q <= '0;
            cnt    <= '0;
            sop_q  <= 1'b0;
            state  <= eop_q ? st_idle : st_stream;
          end
        end
        st_drain: begin
          if (s_valid && s_word.last) begin
            eop_q <= 1'b1;
            state <= st_send;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  assign seg = '{
    hdr:  hdr_q,
    data: data_q,
    strb: strb_q,
    sop:  sop_q,
    eop:  eop_q,
    err:  {3'b000, mal_q}
  };

  // offered segment holds until the fifo takes it
  assert property (@(posedge clk_i) disable iff (rst_i)
    (seg_valid && !seg_ready) |=> (seg_valid && $stable(seg)));

endmodule

`default_nettype wire

// File: hdl/tlp_axis_skid.sv
// ~~~~~~~~~~~~~~~~~~~~
// two-entry skid register for the word stream
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/10ps

module tlp_axis_skid (
  input  wire                    clk_i,
  input  wire                    rst_i,
  input  tlp_rx_pkg::tlp_word_t  in_word,
  input  wire                    in_valid,
  output logic                   in_ready,
  output tlp_rx_pkg::tlp_word_t  out_word,
  output logic                   out_valid,
  input  wire                    out_ready
);
  import tlp_rx_pkg::*;

  // overflow entry, filled only when main is stalled
  tlp_word_t ovf_word;
  logic      ovf_valid;
  logic      ovf_valid_n;
  logic      push;
  logic      pop;

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // overflow fills on push into a stalled main, drains on pop
  always_comb begin
    ovf_valid_n = ovf_valid;
    if (ovf_valid && pop) begin
      ovf_valid_n = 1'b0;
    end else if (push && out_valid && !out_ready) begin
      ovf_valid_n = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_valid <= 1'b0;
      ovf_valid <= 1'b0;
      in_ready  <= 1'b0;
    end else begin
      ovf_valid <= ovf_valid_n;
      // registered ready, no path from out_ready
      in_ready  <= !ovf_valid_n;
      if (!out_valid || out_ready) begin
        // main is free this edge
        out_valid <= ovf_valid || push;
      end
    end
  end

  // payload regs, no reset
  always_ff @(posedge clk_i) begin
    if (!out_valid || out_ready) begin
      out_word <= ovf_valid ? ovf_word : in_word;
    end
    if (push && out_valid && !out_ready) begin
      ovf_word <= in_word;
    end
  end

  // both entries full means upstream must be held off
  assert property (@(posedge clk_i) disable iff (rst_i)
    (out_valid && ovf_valid) |-> !push);

endmodule

`default_nettype wire

// File: hdl/tlp_rx_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// tlp rx types: fmt codes, dw0 view,
// input beat and output segment, dw byte swap
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "tlp_rx_params.svh"

package tlp_rx_pkg;

  // fmt field, wire byte 0 bits 7:5
  // codes 4..7 are treated as malformed
  typedef enum logic [2:0] {
    fmt_3dw_nd = 3'd0,
    fmt_4dw_nd = 3'd1,
    fmt_3dw_wd = 3'd2,
    fmt_4dw_wd = 3'd3
  } tlp_fmt_e;

  // dw0 fields in wire order, length in the low bits
  typedef struct packed {
    logic [2:0]  fmt;
    logic [4:0]  tlp_type;
    // tc, attr, th, td, ep, at
    logic [13:0] tc_attr;
    // 0 encodes 1024 dw
    logic [9:0]  length;
  } tlp_dw0_s;

  // raw word or decoded fields, same 32 bits
  typedef union packed {
    logic [31:0] raw;
    tlp_dw0_s    f;
  } tlp_dw0_u;

  // one input beat, one whole dw
  typedef struct packed {
    logic [31:0] data;
    logic        last;
  } tlp_word_t;

  // one output segment
  // hdr word i at [127-32i -: 32], payload dw 0 at the top of data
  typedef struct packed {
    logic [127:0]           hdr;
    logic [`TLP_SEG_W-1:0]  data;
    logic [`TLP_SEG_DW-1:0] strb;
    logic                   sop;
    logic                   eop;
    // bit 0 malformed, bit 1 length mismatch
    logic [3:0]             err;
  } tlp_seg_t;

  // wire byte order to host order and back
  function automatic logic [31:0] dw_swap(input logic [31:0] dw);
    return {dw[7:0], dw[15:8], dw[23:16], dw[31:24]};
  endfunction

endpackage

`default_nettype wire

// File: hdl/tlp_rx_params.svh
// ~~~~~~~~~~~~~~~~~~~~
// tlp rx sizing macros
// segment width, dw per segment, fifo depth
// ~~~~~~~~~~~~~~~~~~~~
`ifndef TLP_RX_PARAMS_SVH
`define TLP_RX_PARAMS_SVH

// payload dw carried by one segment
`define TLP_SEG_DW 4

// segment data width in bits
`define TLP_SEG_W (32 * `TLP_SEG_DW)

// segment fifo entries, power of two only
`define TLP_FIFO_DEPTH 4

`endif
